/* vsa16.f */
logic/vsaPkg.sv
logic/vsaControl.sv
logic/vsaDatapath.sv
logic/vsaMemory.sv
logic/vsaHostBridge.sv
logic/vsaTop.sv
test/vsaDatapath_checker.sv
test/vsaTb.sv

/* test/vsaStim.txt */
# command then hex addr and data; load counts and step lengths are decimal
# load addr n w.. | step n | expect addr value | errw addr value | errr addr | go | stop | test name
test reset
expect 0004 8000
expect 4000 0000
expect 4002 0000
expect 4004 0000
expect 4006 0000
# ALU program at 0x000, memory program at 0x014, branch loop at 0x01c, loop count at dmem 0x20
load 8000 10 82ff 85fd af05 6d80 6d81 6d82 6d83 6d84 7185 6c00
load 8014 4 2410 2f13 0212 0610
load 801c 7 0220 8400 4803 aa01 9401 41fc 41ff
load c020 1 0003
test alu
step 3
expect 4002 00ff
expect 4004 fffd
expect 4006 01fa
step 1
expect 4006 00fc
step 1
expect 4006 0102
step 1
expect 4006 00fd
step 1
expect 4006 ffff
step 1
expect 4006 ff02
step 1
expect 4006 7ffe
step 1
expect 4000 0000
test memory
step 4
expect 4002 7ffe
expect 4006 fffd
expect c010 fffd
expect c012 7ffe
test branch
step 15
expect 4002 0000
expect 4004 0003
expect 4006 fffd
expect 0004 801d
test busy
go
errw c010 aaaa
errr c012
errw 8000 1234
errw 4002 5555
errw 0004 0001
stop
expect c010 fffd
expect 8000 82ff
expect 4002 0000

/* test/vsaTb.sv */
module vsaTb;
    import vsaPkg::*;

    localparam int pollLimit = 40;      // status reads per wait
    localparam logic [15:0] ctrlAddr = 16'h0000;
    localparam logic [15:0] statusAddr = 16'h0004;

    logic clock;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [15:0] paddr;
    dataWord pwdata;
    dataWord prdata;
    logic pready;
    logic pslverr;

    string testName = "startup";
    logic [11:0] expectedRetired = '0;  // instructions stepped so far

    vsaTop dut_i (
        .clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic failRun();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(string what, dataWord expected, dataWord actual);
        if (actual !== expected) begin
            $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
            failRun();
        end
    endtask

    task automatic checkBit(string what, logic expected, logic actual);
        if (actual !== expected) begin
            $display("** Error %s %s: expected %b, actual %b", testName, what, expected, actual);
            failRun();
        end
    endtask

    // fields read from one stimulus line
    task automatic requireFields(int got, int wanted, string cmd);
        if (got != wanted) begin
            $display("malformed %s line in the stimulus file in test %s", cmd, testName);
            failRun();
        end
    endtask

    // one APB transfer with inputs 1 unit after the edge
    task automatic apbTransfer(input logic write, input logic [15:0] addr,
                               input dataWord wdata, output dataWord rdata, output logic err);
        @(posedge clock);
        #1;
        psel = 1'b1;            // setup phase
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clock);
        #1;
        penable = 1'b1;         // access phase
        #1;
        checkBit("pready in access phase", 1'b1, pready); // zero wait states
        rdata = prdata;
        err = pslverr;
        @(posedge clock);       // transfer completes here
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbWrite(input logic [15:0] addr, input dataWord data, output logic err);
        dataWord unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input logic [15:0] addr, output dataWord data, output logic err);
        apbTransfer(1'b0, addr, '0, data, err);
    endtask

    // poll status until halted and the count matches if asked
    task automatic waitHalted(logic matchCount);
        dataWord status;
        logic err;
        int polls;
        polls = 0;
        apbRead(statusAddr, status, err);
        checkBit("status read slverr", 1'b0, err);
        while (!status[haltedBit] || (matchCount && status[11:0] != expectedRetired)) begin
            polls++;
            if (polls > pollLimit) begin
                $display("core did not halt at retired count %0d in test %s",
                         expectedRetired, testName);
                failRun();
            end
            apbRead(statusAddr, status, err);
            checkBit("status read slverr", 1'b0, err);
        end
        expectedRetired = status[11:0];
    endtask

    // single steps where run drops while the instruction is in flight
    task automatic stepInstructions(int count);
        logic err;
        for (int i = 0; i < count; i++) begin
            apbWrite(ctrlAddr, 16'h0001, err);
            checkBit("run set slverr", 1'b0, err);
            apbWrite(ctrlAddr, 16'h0000, err);
            checkBit("run clear slverr", 1'b0, err);
            expectedRetired++;
            waitHalted(1'b1);
        end
    endtask

    initial begin
        int fd;
        int code;
        int count;
        string cmd;
        logic [15:0] addr;
        dataWord value;
        dataWord actual;
        logic err;
        logic [1023:0] skipLine;

        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        fd = $fopen("test/vsaStim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file test/vsaStim.txt");
            failRun();
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(skipLine, fd);    // rest of a comment line
            end else if (cmd == "test") begin
                code = $fscanf(fd, "%s", testName);
                requireFields(code, 1, cmd);
            end else if (cmd == "load") begin
                code = $fscanf(fd, "%h %d", addr, count);
                requireFields(code, 2, cmd);
                for (int i = 0; i < count; i++) begin
                    code = $fscanf(fd, "%h", value);
                    requireFields(code, 1, cmd);
                    apbWrite(addr + 16'(2 * i), value, err);
                    checkBit($sformatf("load %h slverr", addr + 16'(2 * i)), 1'b0, err);
                end
            end else if (cmd == "step") begin
                code = $fscanf(fd, "%d", count);
                requireFields(code, 1, cmd);
                stepInstructions(count);
            end else if (cmd == "expect") begin
                code = $fscanf(fd, "%h %h", addr, value);
                requireFields(code, 2, cmd);
                apbRead(addr, actual, err);
                checkBit($sformatf("read %h slverr", addr), 1'b0, err);
                checkWord($sformatf("read %h", addr), value, actual);
            end else if (cmd == "errw") begin
                code = $fscanf(fd, "%h %h", addr, value);
                requireFields(code, 2, cmd);
                apbWrite(addr, value, err);
                checkBit($sformatf("write %h slverr", addr), 1'b1, err);
            end else if (cmd == "errr") begin
                code = $fscanf(fd, "%h", addr);
                requireFields(code, 1, cmd);
                apbRead(addr, actual, err);
                checkBit($sformatf("read %h slverr", addr), 1'b1, err);
            end else if (cmd == "go") begin
                apbWrite(ctrlAddr, 16'h0001, err);  // free run
                checkBit("run set slverr", 1'b0, err);
            end else if (cmd == "stop") begin
                apbWrite(ctrlAddr, 16'h0000, err);
                checkBit("run clear slverr", 1'b0, err);
                waitHalted(1'b0);               // count unknown after a free run
            end else begin
                $display("unknown stimulus command %s in test %s", cmd, testName);
                failRun();
            end
        end
        $fclose(fd);

        if (dut_i.datapath_i.checker_i.failures == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("datapath assertions failed %0d times",
                     dut_i.datapath_i.checker_i.failures);
            failRun();
        end
    end

endmodule

/* test/vsaDatapath_checker.sv */
module vsaDatapathChecker (
    input logic            clock,
    input logic            reset,
    input vsaPkg::stateT   state,
    input vsaPkg::opcodeT  opcode,
    input logic [11:0]     pc,
    input vsaPkg::dataWord r0,
    input vsaPkg::dataWord aReg,
    input logic            cond
);
    import vsaPkg::*;

    int failures = 0;   // failed assertion count

    // hardwired zero register
    r0Zero: assert property (@(posedge clock) disable iff (reset) r0 == '0)
        else begin
            failures++;
            $error("R0 holds %h instead of zero", r0);
        end

    // pc only steps in halfword pairs
    pcAligned: assert property (@(posedge clock) disable iff (reset) !pc[0])
        else begin
            failures++;
            $error("pc %h is odd", pc);
        end

    // branch decision follows A once execute is done
    branchCond: assert property (@(posedge clock) disable iff (reset)
        (opcode == BEQZ && (state == memoryState || state == writebackState))
            |-> cond == (aReg == '0))
        else begin
            failures++;
            $error("BEQZ cond %b does not match A %h", cond, aReg);
        end

endmodule

bind vsaDatapath vsaDatapathChecker checker_i (
    .clock(clock), .reset(reset), .state(state), .opcode(opcode), .pc(pc),
    .r0(regFile[0]), .aReg(aReg), .cond(cond)
);

/* logic/vsaTop.sv */
module vsaTop (
    input  logic            clock,
    input  logic            reset,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [15:0]     paddr,
    input  vsaPkg::dataWord pwdata,
    output vsaPkg::dataWord prdata,
    output logic            pready,
    output logic            pslverr
);
    import vsaPkg::*;

    // core side
    stateT state;
    opcodeT opcode;
    funcT func;
    logic halted;
    logic memWrite;
    logic run;
    logic [11:0] retired;
    logic [pcWidth-1:0] pc;
    instrWord instruction;
    dataWord aluResult;
    dataWord storeData;
    dataWord loadData;
    regIndex regSelect;
    dataWord regValue;

    // memory side
    logic [imemAddrWidth-1:0] imemAddr;
    logic imemWrite;
    instrWord imemWdata;
    instrWord imemRdata;
    logic [dmemAddrWidth-1:0] dmemAddr;
    logic dmemWrite;
    dataWord dmemWdata;
    dataWord dmemRdata;

    vsaControl control_i (
        .clock(clock), .reset(reset), .run(run), .opcode(opcode), .func(func),
        .state(state), .halted(halted), .memWrite(memWrite), .retired(retired)
    );

    vsaDatapath datapath_i (
        .clock(clock), .reset(reset), .state(state), .instruction(instruction),
        .loadData(loadData), .regSelect(regSelect), .pc(pc), .opcode(opcode),
        .func(func), .aluResult(aluResult), .storeData(storeData), .regValue(regValue)
    );

    vsaMemory #(.wordType(instrWord), .depth(imemDepth)) imem_i (
        .clock(clock), .addr(imemAddr), .write(imemWrite),
        .wdata(imemWdata), .rdata(imemRdata)
    );

    vsaMemory #(.wordType(dataWord), .depth(dmemDepth)) dmem_i (
        .clock(clock), .addr(dmemAddr), .write(dmemWrite),
        .wdata(dmemWdata), .rdata(dmemRdata)
    );

    vsaHostBridge bridge_i (
        .clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .halted(halted), .retired(retired), .pc(pc),
        .aluResult(aluResult), .storeData(storeData), .memWrite(memWrite),
        .instruction(instruction), .loadData(loadData),
        .imemAddr(imemAddr), .imemWrite(imemWrite), .imemWdata(imemWdata),
        .imemRdata(imemRdata), .dmemAddr(dmemAddr), .dmemWrite(dmemWrite),
        .dmemWdata(dmemWdata), .dmemRdata(dmemRdata),
        .regSelect(regSelect), .regValue(regValue), .run(run)
    );

endmodule

/* logic/vsaHostBridge.sv */
module vsaHostBridge (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [15:0]                        paddr,
    input  vsaPkg::dataWord                    pwdata,
    output vsaPkg::dataWord                    prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  logic                               halted,
    input  logic [11:0]                        retired,
    input  logic [11:0]                        pc,
    input  vsaPkg::dataWord                    aluResult,
    input  vsaPkg::dataWord                    storeData,
    input  logic                               memWrite,
    output vsaPkg::instrWord                   instruction,
    output vsaPkg::dataWord                    loadData,
    output logic [vsaPkg::imemAddrWidth-1:0]   imemAddr,
    output logic                               imemWrite,
    output vsaPkg::instrWord                   imemWdata,
    input  vsaPkg::instrWord                   imemRdata,
    output logic [vsaPkg::dmemAddrWidth-1:0]   dmemAddr,
    output logic                               dmemWrite,
    output vsaPkg::dataWord                    dmemWdata,
    input  vsaPkg::dataWord                    dmemRdata,
    output vsaPkg::regIndex                    regSelect,
    input  vsaPkg::dataWord                    regValue,
    output logic                               run
);
    import vsaPkg::*;

    logic access;
    logic [1:0] region;
    logic [13:0] offset;
    logic memRegion;
    logic illegal;
    logic hostWrite;
    dataWord readMux;

    assign access = psel && penable;    // access phase
    assign region = paddr[15:14];
    assign offset = paddr[13:0];
    assign memRegion = (region == imemRegion) || (region == dmemRegion);

    // rejected accesses
    assign illegal = (region == regRegion && pwrite)
                   || (region == ctrlRegion && pwrite && offset == statusOffset)
                   || (memRegion && !halted);   // core owns the memories
    assign hostWrite = access && pwrite && !illegal;

    assign pready = access;             // zero wait states
    assign pslverr = access && illegal;
    assign prdata = (access && !illegal) ? readMux : '0;

    assign regSelect = paddr[2:1];      // word offset

    always_comb begin
        readMux = '0;
        case (region)
            ctrlRegion: begin
                if (offset == ctrlOffset) begin
                    readMux[0] = run;
                end else if (offset == statusOffset) begin
                    readMux[haltedBit] = halted;
                    readMux[11:0] = retired;
                end
            end
            regRegion:  readMux = regValue;
            imemRegion: readMux = dataWord'(imemRdata);
            default:    readMux = dmemRdata;
        endcase
    end

    // run bit, seen by the sequencer on the next edge
    always_ff @(posedge clock) begin
        if (reset) begin
            run <= 1'b0;
        end else if (hostWrite && region == ctrlRegion && offset == ctrlOffset) begin
            run <= pwdata[0];
        end
    end

    // memory ports go to the host only while halted
    assign imemAddr = halted ? paddr[imemAddrWidth:1] : pc[imemAddrWidth:1];
    assign imemWrite = halted && hostWrite && region == imemRegion;
    assign imemWdata = instrWord'(pwdata);
    assign instruction = imemRdata;

    assign dmemAddr = halted ? paddr[dmemAddrWidth:1] : aluResult[dmemAddrWidth:1];
    assign dmemWrite = halted ? (hostWrite && region == dmemRegion) : memWrite;
    assign dmemWdata = halted ? pwdata : storeData;
    assign loadData = dmemRdata;

endmodule

/* logic/vsaMemory.sv */
module vsaMemory #(
    parameter type wordType = vsaPkg::dataWord,
    parameter int  depth = vsaPkg::dmemDepth
) (
    input  logic                     clock,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic                     write,
    input  wordType                  wdata,
    output wordType                  rdata
);

    wordType mem [depth];   // contents loaded by the host

    // combinational read without wait state
    assign rdata = mem[addr];

    // single port write on the edge
    always_ff @(posedge clock) begin
        if (write) begin
            mem[addr] <= wdata;
        end
    end

endmodule

/* logic/vsaDatapath.sv */
module vsaDatapath (
    input  logic             clock,
    input  logic             reset,
    input  vsaPkg::stateT    state,
    input  vsaPkg::instrWord instruction,
    input  vsaPkg::dataWord  loadData,
    input  vsaPkg::regIndex  regSelect,
    output logic [11:0]      pc,
    output vsaPkg::opcodeT   opcode,
    output vsaPkg::funcT     func,
    output vsaPkg::dataWord  aluResult,
    output vsaPkg::dataWord  storeData,
    output vsaPkg::dataWord  regValue
);
    import vsaPkg::*;

    instrWord ir;                   // instruction register
    logic [pcWidth-1:0] npc;        // sequential next pc
    dataWord aReg;                  // first operand
    dataWord bReg;                  // second operand, also store data
    dataWord aluOut;
    logic cond;                     // branch taken
    dataWord lmd;                   // load data
    dataWord regFile [4];

    regIndex dst;
    dataWord immExt;
    dataWord aluNext;
    logic memRef;
    logic regRegAlu;
    logic regImmAlu;
    logic branch;
    logic wbEnable;
    regIndex wbIndex;
    dataWord wbData;

    // fields of IR
    assign opcode = ir.opcode;
    assign func = funcT'(ir.tail[6:0]);
    assign dst = ir.tail[8:7];
    assign immExt = {{(dataWidth - 9){ir.tail[8]}}, ir.tail}; // 9-bit sign extension

    // instruction classes
    assign memRef = (opcode == LW) || (opcode == SW);
    assign regRegAlu = (opcode == ALUOP);
    assign regImmAlu = (opcode == ADDI) || (opcode == SUBI);
    assign branch = (opcode == BEQZ);

    assign aluResult = aluOut;      // data address for loads and stores
    assign storeData = bReg;
    assign regValue = regFile[regSelect]; // host read port

    always_comb begin
        aluNext = aluOut;           // unknown codes keep the old value
        if (memRef) begin
            aluNext = aReg + immExt; // effective address
        end else if (regRegAlu) begin
            case (func)
                FADD: aluNext = aReg + bReg;
                FSUB: aluNext = aReg - bReg;
                FAND: aluNext = aReg & bReg;
                FOR:  aluNext = aReg | bReg;
                FXOR: aluNext = aReg ^ bReg;
                FSRL: aluNext = {1'b0, aReg[dataWidth-1:1]}; // logical, by one
                default: aluNext = aluOut;
            endcase
        end else if (regImmAlu) begin
            aluNext = (opcode == ADDI) ? aReg + immExt : aReg - immExt;
        end else if (branch) begin
            // target is npc plus twice the immediate
            aluNext = {{(dataWidth - pcWidth){1'b0}}, npc} + (immExt << 1);
        end
    end

    // write-back selection
    assign wbIndex = regRegAlu ? dst : ir.src2;   // I-format writes src2
    assign wbData = (opcode == LW) ? lmd : aluOut;
    assign wbEnable = knownInstr(opcode, func) && (regRegAlu || regImmAlu || opcode == LW);

    // architectural state
    always_ff @(posedge clock) begin
        if (reset) begin
            ir <= '0;
            pc <= '0;
            regFile <= '{default: '0};
        end else begin
            case (state)
                fetchState: begin
                    ir <= instruction;
                end
                memoryState: begin
                    pc <= (branch && cond) ? aluOut[pcWidth-1:0] : npc;
                end
                writebackState: begin
                    if (wbEnable && wbIndex != 2'd0) begin // R0 stays zero
                        regFile[wbIndex] <= wbData;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // staging registers
    always_ff @(posedge clock) begin
        case (state)
            fetchState: begin
                npc <= pc + 12'd2;
            end
            decodeState: begin
                aReg <= regFile[ir.src1];
                bReg <= regFile[ir.src2];
            end
            executeState: begin
                aluOut <= aluNext;
                if (branch) begin
                    cond <= (aReg == '0);
                end
            end
            memoryState: begin
                if (opcode == LW) begin
                    lmd <= loadData;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* logic/vsaControl.sv */
module vsaControl (
    input  logic           clock,
    input  logic           reset,
    input  logic           run,
    input  vsaPkg::opcodeT opcode,
    input  vsaPkg::funcT   func,
    output vsaPkg::stateT  state,
    output logic           halted,
    output logic           memWrite,
    output logic [11:0]    retired
);
    import vsaPkg::*;

    stateT nextState;
    logic storeInstr;
    logic retire;

    // instruction class
    assign storeInstr = (opcode == SW);
    assign retire = (state == writebackState) && knownInstr(opcode, func); // skip undefined codes

    // only parked at an instruction boundary
    assign halted = (state == fetchState) && !run;

    // store strobe for one cycle
    assign memWrite = (state == memoryState) && storeInstr;

    always_comb begin
        case (state)
            fetchState: begin
                nextState = run ? decodeState : fetchState; // hold here while stopped
            end
            decodeState: begin
                nextState = executeState;
            end
            executeState: begin
                nextState = memoryState;
            end
            memoryState: begin
                nextState = writebackState;
            end
            writebackState: begin
                nextState = fetchState;
            end
            default: begin
                nextState = fetchState; // unused encodings recover
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= fetchState;
        end else begin
            state <= nextState;
        end
    end

    // completed instruction count, wraps
    always_ff @(posedge clock) begin
        if (reset) begin
            retired <= '0;
        end else if (retire) begin
            retired <= retired + 12'd1;
        end
    end

endmodule

/* logic/vsaPkg.sv */
package vsaPkg;

    localparam int dataWidth = 16;
    localparam int pcWidth = 12;            // byte address, steps by 2
    localparam int dmemDepth = 256;         // words
    localparam int imemDepth = 2048;        // words, covers the whole pc range
    localparam int imemAddrWidth = $clog2(imemDepth);
    localparam int dmemAddrWidth = $clog2(dmemDepth);

    // host map, region sits in paddr[15:14]
    localparam logic [1:0] ctrlRegion = 2'd0;
    localparam logic [1:0] regRegion = 2'd1;    // read only
    localparam logic [1:0] imemRegion = 2'd2;
    localparam logic [1:0] dmemRegion = 2'd3;
    localparam logic [13:0] ctrlOffset = 14'd0;   // bit 0 is run
    localparam logic [13:0] statusOffset = 14'd4; // halted and retired count
    localparam int haltedBit = 15;

    typedef logic [dataWidth-1:0] dataWord;
    typedef logic [1:0] regIndex;

    typedef enum logic [2:0] {
        fetchState = 3'd0,
        decodeState = 3'd1,
        executeState = 3'd2,
        memoryState = 3'd3,
        writebackState = 3'd4
    } stateT;

    typedef enum logic [2:0] {
        LW = 3'd0,
        SW = 3'd1,
        BEQZ = 3'd2,
        ALUOP = 3'd3,
        ADDI = 3'd4,
        SUBI = 3'd5
    } opcodeT;

    typedef enum logic [6:0] {
        FADD = 7'd0,
        FSUB = 7'd1,
        FAND = 7'd2,
        FOR = 7'd3,
        FXOR = 7'd4,
        FSRL = 7'd5
    } funcT;

    // tail is dst plus func for R-format, imm for I-format
    typedef struct packed {
        opcodeT opcode;
        regIndex src1;
        regIndex src2;
        logic [8:0] tail;
    } instrWord;

    // true for every opcode and func the core implements
    function automatic logic knownInstr(opcodeT op, funcT fn);
        case (op)
            LW, SW, BEQZ, ADDI, SUBI: return 1'b1;
            ALUOP: return fn <= FSRL;
            default: return 1'b0;
        endcase
    endfunction

endpackage
